//--- rtl/tri_mem_consts.svh
`ifndef TRI_MEM_CONSTS_SVH
`define TRI_MEM_CONSTS_SVH

// triangle capacity of the index table
`define TRI_NUM_TRIANGLE 512

// triangle id width
`define TRI_ID_W ($clog2(`TRI_NUM_TRIANGLE))

// vertex capacity, three per triangle
`define TRI_NUM_VERTEX 1536

// vertex table address width
`define TRI_VTX_ADDR_W ($clog2(`TRI_NUM_VERTEX))

// input buffer depth and initial credits of the memory controller
`define TRI_LOAD_CREDITS 2

`endif

//--- rtl/tri_load_pkg.sv
`default_nettype none

package tri_load_pkg;

    // index record as it arrives from the memory controller
    typedef struct packed {
        logic [31:0] sid;
        logic [31:0] idx2;
        logic [31:0] idx1;
        logic [31:0] idx0;
    } mc_index_view_t;

    // vertex record, a zero flag ends the vertex run
    typedef struct packed {
        logic [31:0] flag;
        logic [31:0] z;
        logic [31:0] y;
        logic [31:0] x;
    } mc_vertex_view_t;

    // one load word, decoded by the current load phase
    typedef union packed {
        mc_index_view_t  idx;
        mc_vertex_view_t vtx;
    } mc_word_u;

    typedef enum logic [1:0] {
        phase_idle,
        phase_index,
        phase_vertex
    } load_phase_e;

endpackage

`default_nettype wire

//--- rtl/tri_read_pkg.sv
`default_nettype none

package tri_read_pkg;

    // one vertex as handed to the intersection core
    typedef struct packed {
        logic [31:0] z;
        logic [31:0] y;
        logic [31:0] x;
    } vertex_t;

    // one entry of the index table
    typedef struct packed {
        logic [31:0] sid;
        logic [31:0] idx2;
        logic [31:0] idx1;
        logic [31:0] idx0;
    } index_rec_t;

    // read sequence, one state per table access
    typedef enum logic [2:0] {
        fetch_idle,
        fetch_index,
        fetch_vtx0,
        fetch_vtx1,
        fetch_vtx2,
        fetch_done
    } fetch_state_e;

endpackage

`default_nettype wire

//--- rtl/tbl_rd_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "tri_mem_consts.svh"

interface tbl_rd_if #(
    parameter int ADDR_W = `TRI_ID_W,
    parameter int DATA_W = 128
) ();

    logic              re;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rdata;
    // high in the cycle after re
    logic              rvalid;

    modport tbl (input re, input addr, output rdata, output rvalid);

    modport reader (output re, output addr, input rdata, input rvalid);

endinterface

`default_nettype wire

//--- rtl/mc_loader.sv
`timescale 1ns/1ps
`default_nettype none
`include "tri_mem_consts.svh"

module mc_loader
    import tri_load_pkg::*;
    import tri_read_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        mc_valid,
    input  mc_word_u                    mc_data,
    output logic                        mc_credit,
    output logic                        idx_we,
    output logic [`TRI_ID_W-1:0]        idx_addr,
    output index_rec_t                  idx_data,
    output logic                        vtx_we,
    output logic [`TRI_VTX_ADDR_W-1:0]  vtx_addr,
    output vertex_t                     vtx_data,
    output logic [`TRI_ID_W:0]          tri_count,
    output logic                        loading
);

    localparam int depth = `TRI_LOAD_CREDITS;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    mc_word_u buf_mem [depth];

    logic [ptr_w-1:0]           wr_ptr_q;
    logic [ptr_w-1:0]           rd_ptr_q;
    logic [cnt_w-1:0]           fill_q;
    load_phase_e                phase_q;
    logic [`TRI_ID_W:0]         idx_cnt_q;
    logic [`TRI_VTX_ADDR_W-1:0] vtx_cnt_q;

    mc_word_u head;
    logic     pop;
    logic     in_index;
    logic     idx_end;
    logic     vtx_end;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // drain one word per cycle
    assign pop  = (fill_q != '0);
    assign head = buf_mem[rd_ptr_q];

    // a word seen in idle opens the index run
    assign in_index = (phase_q != phase_vertex);
    assign idx_end  = pop && in_index && (head.idx.sid == '0);
    assign vtx_end  = pop && !in_index && (head.vtx.flag == '0);

    // every word taken from the buffer frees a slot
    assign mc_credit = pop;

    assign idx_we   = pop && in_index && !idx_end;
    assign idx_addr = idx_cnt_q[`TRI_ID_W-1:0];
    assign idx_data = '{sid: head.idx.sid, idx2: head.idx.idx2,
                        idx1: head.idx.idx1, idx0: head.idx.idx0};

    assign vtx_we   = pop && !in_index && !vtx_end;
    assign vtx_addr = vtx_cnt_q;
    assign vtx_data = '{z: head.vtx.z, y: head.vtx.y, x: head.vtx.x};

    assign loading = mc_valid || pop || (phase_q != phase_idle);

    always_ff @(posedge clk) begin
        if (mc_valid) begin
            buf_mem[wr_ptr_q] <= mc_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            fill_q    <= '0;
            phase_q   <= phase_idle;
            idx_cnt_q <= '0;
            vtx_cnt_q <= '0;
            tri_count <= '0;
        end else begin
            if (mc_valid) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            fill_q <= fill_q + cnt_w'(mc_valid) - cnt_w'(pop);

            if (pop) begin
                case (phase_q)
                    phase_idle, phase_index: begin
                        if (idx_end) begin
                            // count is final and vertices start at 0
                            phase_q   <= phase_vertex;
                            tri_count <= idx_cnt_q;
                            vtx_cnt_q <= '0;
                        end else begin
                            phase_q   <= phase_index;
                            idx_cnt_q <= idx_cnt_q + 1'b1;
                        end
                    end
                    phase_vertex: begin
                        if (vtx_end) begin
                            phase_q   <= phase_idle;
                            idx_cnt_q <= '0;
                        end else begin
                            vtx_cnt_q <= vtx_cnt_q + 1'b1;
                        end
                    end
                    default: phase_q <= phase_idle;
                endcase
            end
        end
    end

    // the index run has to fit the index table
    idx_run_fits: assert property (@(posedge clk) disable iff (!rst_n)
        idx_we |-> (idx_cnt_q < `TRI_NUM_TRIANGLE));

endmodule

`default_nettype wire

//--- rtl/index_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "tri_mem_consts.svh"

module index_table
    import tri_read_pkg::*;
(
    input  logic                 clk,
    input  logic                 wr_we,
    input  logic [`TRI_ID_W-1:0] wr_addr,
    input  index_rec_t           wr_data,
    tbl_rd_if.tbl                rd
);

    // one record per triangle
    index_rec_t mem [`TRI_NUM_TRIANGLE];

    always_ff @(posedge clk) begin
        if (wr_we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd.re) begin
            rd.rdata <= mem[rd.addr];
        end
    end

    always_ff @(posedge clk) begin
        rd.rvalid <= rd.re;
    end

endmodule

`default_nettype wire

//--- rtl/vertex_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "tri_mem_consts.svh"

module vertex_table
    import tri_read_pkg::*;
(
    input  logic                       clk,
    input  logic                       wr_we,
    input  logic [`TRI_VTX_ADDR_W-1:0] wr_addr,
    input  vertex_t                    wr_data,
    tbl_rd_if.tbl                      rd
);

    // x, y, z of every loaded vertex
    vertex_t mem [`TRI_NUM_VERTEX];

    always_ff @(posedge clk) begin
        if (wr_we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd.re) begin
            rd.rdata <= mem[rd.addr];
        end
    end

    always_ff @(posedge clk) begin
        rd.rvalid <= rd.re;
    end

endmodule

`default_nettype wire

//--- rtl/triangle_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "tri_mem_consts.svh"

module triangle_fetch
    import tri_read_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ic_req,
    input  logic [`TRI_ID_W-1:0] ic_id,
    input  logic [`TRI_ID_W:0]   tri_count,
    input  logic                 loading,
    tbl_rd_if.reader             idx_rd,
    tbl_rd_if.reader             vtx_rd,
    output logic                 ic_rdy,
    output logic                 ic_not_valid,
    output vertex_t              vertex0,
    output vertex_t              vertex1,
    output vertex_t              vertex2,
    output logic [31:0]          sid
);

    fetch_state_e         state_q;
    fetch_state_e         state_d;
    logic                 demand_q;
    logic [`TRI_ID_W-1:0] cur_id_q;
    logic [`TRI_ID_W-1:0] pf_id_q;
    logic                 pf_valid_q;
    logic                 want_pf_q;
    logic [`TRI_ID_W:0]   nxt_id_q;

    // shadow buffer filled by every fetch
    index_rec_t sh_rec_q;
    vertex_t    sh_v0_q;
    vertex_t    sh_v1_q;
    vertex_t    sh_v2_q;

    index_rec_t idx_word;
    vertex_t    vtx_word;
    logic       in_range;
    logic       req_ok;
    logic       req_bad;
    logic       pf_run;
    logic       take_over;
    logic       restart;
    logic       hit;
    logic       miss;
    logic       start_pf;
    logic       ans_shadow;
    logic       ans_direct;

    assign idx_word = index_rec_t'(idx_rd.rdata);
    assign vtx_word = vertex_t'(vtx_rd.rdata);

    assign in_range = ({1'b0, ic_id} < tri_count);
    assign req_ok   = ic_req && in_range;
    assign req_bad  = ic_req && !in_range;

    // request against a running prefetch: same id keeps going, other id restarts
    assign pf_run    = (state_q != fetch_idle) && !demand_q;
    assign take_over = req_ok && pf_run && (ic_id == cur_id_q);
    assign restart   = req_ok && pf_run && (ic_id != cur_id_q);

    assign hit  = req_ok && (state_q == fetch_idle) && pf_valid_q && (ic_id == pf_id_q);
    assign miss = req_ok && (state_q == fetch_idle) && !hit;

    // background fetch of the next id once the core is quiet
    assign start_pf = (state_q == fetch_idle) && !ic_req && want_pf_q && (nxt_id_q < tri_count);

    assign ans_shadow = hit || ((state_q == fetch_done) && take_over);
    assign ans_direct = (state_q == fetch_vtx2) && (demand_q || take_over) && vtx_rd.rvalid;

    always_comb begin
        state_d     = state_q;
        idx_rd.re   = 1'b0;
        idx_rd.addr = ic_id;
        vtx_rd.re   = 1'b0;
        vtx_rd.addr = '0;
        if (loading) begin
            state_d = fetch_idle;
        end else if (miss || restart) begin
            idx_rd.re = 1'b1;
            state_d   = fetch_index;
        end else if (start_pf) begin
            idx_rd.re   = 1'b1;
            idx_rd.addr = nxt_id_q[`TRI_ID_W-1:0];
            state_d     = fetch_index;
        end else begin
            case (state_q)
                fetch_index: begin
                    // first vertex address straight from the table output
                    vtx_rd.re   = 1'b1;
                    vtx_rd.addr = idx_word.idx0[`TRI_VTX_ADDR_W-1:0];
                    state_d     = fetch_vtx0;
                end
                fetch_vtx0: begin
                    vtx_rd.re   = 1'b1;
                    vtx_rd.addr = sh_rec_q.idx1[`TRI_VTX_ADDR_W-1:0];
                    state_d     = fetch_vtx1;
                end
                fetch_vtx1: begin
                    vtx_rd.re   = 1'b1;
                    vtx_rd.addr = sh_rec_q.idx2[`TRI_VTX_ADDR_W-1:0];
                    state_d     = fetch_vtx2;
                end
                fetch_vtx2: state_d = (demand_q || take_over) ? fetch_idle : fetch_done;
                default:    state_d = fetch_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= fetch_idle;
            demand_q     <= 1'b0;
            cur_id_q     <= '0;
            pf_id_q      <= '0;
            pf_valid_q   <= 1'b0;
            want_pf_q    <= 1'b0;
            nxt_id_q     <= '0;
            ic_rdy       <= 1'b0;
            ic_not_valid <= 1'b0;
        end else begin
            state_q      <= state_d;
            ic_rdy       <= ans_shadow || ans_direct;
            ic_not_valid <= req_bad;
            if (loading) begin
                // table contents change under us
                demand_q   <= 1'b0;
                pf_valid_q <= 1'b0;
                want_pf_q  <= 1'b0;
            end else begin
                if (miss || restart) begin
                    cur_id_q   <= ic_id;
                    demand_q   <= 1'b1;
                    pf_valid_q <= 1'b0;
                end else if (take_over) begin
                    demand_q <= 1'b1;
                end
                if ((state_q == fetch_idle) && !ic_req && want_pf_q) begin
                    want_pf_q <= 1'b0;
                end
                if (start_pf) begin
                    cur_id_q   <= nxt_id_q[`TRI_ID_W-1:0];
                    demand_q   <= 1'b0;
                    pf_valid_q <= 1'b0;
                end
                if ((state_q == fetch_done) && !take_over && !restart) begin
                    pf_valid_q <= 1'b1;
                    pf_id_q    <= cur_id_q;
                end
                if (ans_shadow) begin
                    want_pf_q <= 1'b1;
                    nxt_id_q  <= {1'b0, ic_id} + 1'b1;
                end else if (ans_direct) begin
                    want_pf_q <= 1'b1;
                    nxt_id_q  <= {1'b0, cur_id_q} + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == fetch_index) && idx_rd.rvalid) begin
            sh_rec_q <= idx_word;
        end
        if ((state_q == fetch_vtx0) && vtx_rd.rvalid) begin
            sh_v0_q <= vtx_word;
        end
        if ((state_q == fetch_vtx1) && vtx_rd.rvalid) begin
            sh_v1_q <= vtx_word;
        end
        if ((state_q == fetch_vtx2) && vtx_rd.rvalid) begin
            sh_v2_q <= vtx_word;
        end
        // outputs hold until the next answer
        if (ans_shadow) begin
            vertex0 <= sh_v0_q;
            vertex1 <= sh_v1_q;
            vertex2 <= sh_v2_q;
            sid     <= sh_rec_q.sid;
        end else if (ans_direct) begin
            vertex0 <= sh_v0_q;
            vertex1 <= sh_v1_q;
            vertex2 <= vtx_word;
            sid     <= sh_rec_q.sid;
        end
    end

    no_req_while_loading: assert property (@(posedge clk) disable iff (!rst_n)
        loading |-> !ic_req);

    // one outstanding request, closed by either answer
    one_req_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        ic_req |=> !ic_req until (ic_rdy || ic_not_valid));

endmodule

`default_nettype wire

//--- rtl/tri_mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "tri_mem_consts.svh"

module tri_mem_top
    import tri_load_pkg::*;
    import tri_read_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mc_valid,
    input  mc_word_u             mc_data,
    output logic                 mc_credit,
    input  logic                 ic_req,
    input  logic [`TRI_ID_W-1:0] ic_id,
    output logic                 ic_rdy,
    output logic                 ic_not_valid,
    output vertex_t              vertex0,
    output vertex_t              vertex1,
    output vertex_t              vertex2,
    output logic [31:0]          sid
);

    logic                       idx_we;
    logic [`TRI_ID_W-1:0]       idx_addr;
    index_rec_t                 idx_data;
    logic                       vtx_we;
    logic [`TRI_VTX_ADDR_W-1:0] vtx_addr;
    vertex_t                    vtx_data;
    logic [`TRI_ID_W:0]         tri_count;
    logic                       loading;

    tbl_rd_if #(.ADDR_W(`TRI_ID_W), .DATA_W($bits(index_rec_t))) idx_rd_if ();
    tbl_rd_if #(.ADDR_W(`TRI_VTX_ADDR_W), .DATA_W($bits(vertex_t))) vtx_rd_if ();

    mc_loader mc_loader_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mc_valid  (mc_valid),
        .mc_data   (mc_data),
        .mc_credit (mc_credit),
        .idx_we    (idx_we),
        .idx_addr  (idx_addr),
        .idx_data  (idx_data),
        .vtx_we    (vtx_we),
        .vtx_addr  (vtx_addr),
        .vtx_data  (vtx_data),
        .tri_count (tri_count),
        .loading   (loading)
    );

    index_table index_table_i (
        .clk     (clk),
        .wr_we   (idx_we),
        .wr_addr (idx_addr),
        .wr_data (idx_data),
        .rd      (idx_rd_if.tbl)
    );

    vertex_table vertex_table_i (
        .clk     (clk),
        .wr_we   (vtx_we),
        .wr_addr (vtx_addr),
        .wr_data (vtx_data),
        .rd      (vtx_rd_if.tbl)
    );

    triangle_fetch triangle_fetch_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ic_req       (ic_req),
        .ic_id        (ic_id),
        .tri_count    (tri_count),
        .loading      (loading),
        .idx_rd       (idx_rd_if.reader),
        .vtx_rd       (vtx_rd_if.reader),
        .ic_rdy       (ic_rdy),
        .ic_not_valid (ic_not_valid),
        .vertex0      (vertex0),
        .vertex1      (vertex1),
        .vertex2      (vertex2),
        .sid          (sid)
    );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset drops on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/tri_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "tri_mem_consts.svh"

module tri_mem_tb
    import tri_load_pkg::*;
    import tri_read_pkg::*;
();

    typedef struct packed {
        logic        valid;
        logic [31:0] sid;
        vertex_t     v0;
        vertex_t     v1;
        vertex_t     v2;
    } answer_t;

    localparam int max_wait = 40;

    logic                 clk;
    logic                 rst_n;
    logic                 mc_valid;
    mc_word_u             mc_data;
    logic                 mc_credit;
    logic                 ic_req;
    logic [`TRI_ID_W-1:0] ic_id;
    logic                 ic_rdy;
    logic                 ic_not_valid;
    vertex_t              vertex0;
    vertex_t              vertex1;
    vertex_t              vertex2;
    logic [31:0]          sid;

    // scene as sent to the DUT
    logic [127:0] tri_rec [`TRI_NUM_TRIANGLE];
    vertex_t      vtx_mem [`TRI_NUM_VERTEX];
    int           tri_n;

    integer  seed;
    int      errors;
    bit      timed_out;
    int      credits;
    int      cyc = 0;
    int      lat;
    bit      pending;
    answer_t pend_exp;
    int      pend_cyc;
    int      pend_lat;
    int      pend_id;
    string   test_name;

    tb_clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tri_mem_top tri_mem_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mc_valid     (mc_valid),
        .mc_data      (mc_data),
        .mc_credit    (mc_credit),
        .ic_req       (ic_req),
        .ic_id        (ic_id),
        .ic_rdy       (ic_rdy),
        .ic_not_valid (ic_not_valid),
        .vertex0      (vertex0),
        .vertex1      (vertex1),
        .vertex2      (vertex2),
        .sid          (sid)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // expected answer straight from the scene arrays
    function automatic answer_t ref_lookup(input int id);
        answer_t      a;
        logic [127:0] rec;
        a = '0;
        if (id < tri_n) begin
            rec     = tri_rec[id];
            a.valid = 1'b1;
            a.sid   = rec[127:96];
            a.v0    = vtx_mem[rec[31:0]];
            a.v1    = vtx_mem[rec[63:32]];
            a.v2    = vtx_mem[rec[95:64]];
        end
        return a;
    endfunction

    task automatic count_credit();
        if (mc_credit) begin
            credits++;
        end
        assert (credits >= 0 && credits <= `TRI_LOAD_CREDITS) else begin
            errors++;
            $display("Fail %s credits: expected 0..%0d, actual %0d",
                     test_name, `TRI_LOAD_CREDITS, credits);
        end
    endtask

    // memory controller sends only with a credit in hand
    task automatic send_word(input logic [127:0] w);
        int t;
        bit sent;
        if (timed_out) return;
        t    = 0;
        sent = 1'b0;
        while (!sent && t < max_wait) begin
            @(negedge clk);
            count_credit();
            if (credits > 0 && ($random(seed) & 3) != 0) begin
                mc_valid = 1'b1;
                mc_data  = w;
                credits--;
                sent     = 1'b1;
            end else begin
                mc_valid = 1'b0;
            end
            t++;
        end
        if (!sent) begin
            errors++;
            timed_out = 1'b1;
            $display("no credit came back, load word could not be sent");
        end
    endtask

    task automatic drain_credits();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            mc_valid = 1'b0;
            count_credit();
            t++;
        end while (credits != `TRI_LOAD_CREDITS && t < max_wait);
        assert (credits == `TRI_LOAD_CREDITS) else begin
            errors++;
            timed_out = 1'b1;
            $display("credits did not all come back after the terminating word");
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic load_scene(input int ntri, input int nvtx);
        int unsigned i0;
        int unsigned i1;
        int unsigned i2;
        if (timed_out) return;
        for (int i = 0; i < nvtx; i++) begin
            vtx_mem[i] = {$random(seed), $random(seed), $random(seed)};
        end
        // sid must be nonzero since zero ends the index run
        for (int i = 0; i < ntri; i++) begin
            i0 = $unsigned($random(seed)) % nvtx;
            i1 = $unsigned($random(seed)) % nvtx;
            i2 = $unsigned($random(seed)) % nvtx;
            tri_rec[i] = {32'($random(seed)) | 32'h1, i2, i1, i0};
        end
        tri_n = ntri;
        for (int i = 0; i < ntri; i++) begin
            send_word(tri_rec[i]);
        end
        send_word({32'h0, 32'($random(seed)), 64'h0});
        for (int i = 0; i < nvtx; i++) begin
            send_word({32'($random(seed)) | 32'h1, vtx_mem[i]});
        end
        send_word({32'h0, 32'($random(seed)), 64'h0});
        drain_credits();
    endtask

    // one request and a wait for either answer
    task automatic read_tri(input int id, input int gap, input int exp_lat);
        int t;
        bit done;
        if (timed_out) return;
        repeat (gap) @(negedge clk);
        @(negedge clk);
        ic_req   = 1'b1;
        ic_id    = id[`TRI_ID_W-1:0];
        pend_exp = ref_lookup(id);
        pend_cyc = cyc;
        pend_lat = exp_lat;
        pend_id  = id;
        pending  = 1'b1;
        t        = 0;
        done     = 1'b0;
        while (!done && t < max_wait) begin
            @(negedge clk);
            ic_req = 1'b0;
            done   = ic_rdy || ic_not_valid;
            t++;
        end
        if (!done) begin
            errors++;
            timed_out = 1'b1;
            $display("no answer came for id %0d in %s", id, test_name);
        end
    endtask

    // compares every answer against the pending expectation
    always @(negedge clk) begin
        if (rst_n && (ic_rdy || ic_not_valid)) begin
            assert (pending) else begin
                errors++;
                $display("an answer came with no request pending");
            end
            if (pending) begin
                lat = cyc - pend_cyc;
                assert (ic_rdy == pend_exp.valid && ic_not_valid == !pend_exp.valid) else begin
                    errors++;
                    $display("Fail %s id %0d valid: expected %0b, actual %0b",
                             test_name, pend_id, pend_exp.valid, ic_rdy);
                end
                if (pend_exp.valid) begin
                    assert (sid == pend_exp.sid) else begin
                        errors++;
                        $display("Fail %s id %0d sid: expected %h, actual %h",
                                 test_name, pend_id, pend_exp.sid, sid);
                    end
                    assert (vertex0 == pend_exp.v0) else begin
                        errors++;
                        $display("Fail %s id %0d vertex0: expected %h, actual %h",
                                 test_name, pend_id, pend_exp.v0, vertex0);
                    end
                    assert (vertex1 == pend_exp.v1) else begin
                        errors++;
                        $display("Fail %s id %0d vertex1: expected %h, actual %h",
                                 test_name, pend_id, pend_exp.v1, vertex1);
                    end
                    assert (vertex2 == pend_exp.v2) else begin
                        errors++;
                        $display("Fail %s id %0d vertex2: expected %h, actual %h",
                                 test_name, pend_id, pend_exp.v2, vertex2);
                    end
                end
                if (pend_lat >= 0) begin
                    assert (lat == pend_lat) else begin
                        errors++;
                        $display("Fail %s id %0d latency: expected %0d, actual %0d",
                                 test_name, pend_id, pend_lat, lat);
                    end
                end
                pending = 1'b0;
            end
        end
    end

    initial begin
        int order [20];
        int j;
        int tmp;
        int t;
        seed      = 85244;
        errors    = 0;
        timed_out = 1'b0;
        credits   = `TRI_LOAD_CREDITS;
        pending   = 1'b0;
        tri_n     = 0;
        mc_valid  = 1'b0;
        mc_data   = '0;
        ic_req    = 1'b0;
        ic_id     = '0;
        test_name = "reset";
        t = 0;
        while (rst_n !== 1'b1 && t < 20) begin
            @(posedge clk);
            t++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            $display("reset was never released");
        end

        // nothing loaded yet so the count is zero
        test_name = "after reset";
        read_tri(0, 1, 1);

        test_name = "random order";
        load_scene(20, 30);
        for (int i = 0; i < 20; i++) begin
            order[i] = i;
        end
        for (int i = 19; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 20; i++) begin
            read_tri(order[i], 1 + $unsigned($random(seed)) % 8, -1);
        end

        // long gaps let the prefetch finish and short ones catch it running
        test_name = "sequential";
        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 0) begin
                read_tri(i, 10, (i == 0) ? 5 : 1);
            end else begin
                read_tri(i, 1, -1);
            end
        end

        test_name = "out of range";
        read_tri(20, 1, 1);
        read_tri(21, 2, 1);
        read_tri(300, 1, 1);
        read_tri(511, 1, 1);
        test_name = "valid after out of range";
        read_tri(7, 1, -1);

        test_name = "reload";
        repeat (4) @(negedge clk);
        load_scene(12, 25);
        for (int i = 12; i < 20; i++) begin
            read_tri(i, 1, 1);
        end
        for (int i = 0; i < 12; i++) begin
            read_tri(i, 1 + $unsigned($random(seed)) % 6, -1);
        end

        repeat (5) @(negedge clk);
        $display("errors: %0d, timeouts: %0d", errors, timed_out);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/tri_load_pkg.sv
rtl/tri_read_pkg.sv
rtl/tbl_rd_if.sv
rtl/mc_loader.sv
rtl/index_table.sv
rtl/vertex_table.sv
rtl/triangle_fetch.sv
rtl/tri_mem_top.sv
verif/tb_clk_gen.sv
verif/tri_mem_tb.sv

//--- Bender.yml
package:
  name: tri_mem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tri_load_pkg.sv
      - rtl/tri_read_pkg.sv
      - rtl/tbl_rd_if.sv
      - rtl/mc_loader.sv
      - rtl/index_table.sv
      - rtl/vertex_table.sv
      - rtl/triangle_fetch.sv
      - rtl/tri_mem_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_clk_gen.sv
      - verif/tri_mem_tb.sv
